/* list.f */
rtl/cpu_pkg.sv
rtl/instr_decoder.sv
rtl/fetch_unit.sv
rtl/hazard_unit.sv
rtl/alu.sv
rtl/execute_stage.sv
rtl/processor.sv
verif/processor_asserts.sv
verif/tb_processor.sv

/* rtl/alu.sv */
// integer alu
`timescale 1ns/100ps
`default_nettype none

module alu #(
    parameter int width = 32
) (
    input  logic [width-1:0] a,
    input  logic [width-1:0] b,
    input  logic [4:0]       op,
    input  logic [4:0]       shamt,
    output logic [width-1:0] result,
    output logic             overflow,
    output logic             not_equal,
    output logic             less_than
);

    logic [width-1:0] sum;
    logic [width-1:0] diff;
    logic             add_ovf;
    logic             sub_ovf;

    assign sum  = a + b;
    assign diff = a - b;

    // sign of result differs from what the operands allow
    assign add_ovf = (a[width-1] == b[width-1]) && (sum[width-1] != a[width-1]);
    assign sub_ovf = (a[width-1] != b[width-1]) && (diff[width-1] != a[width-1]);

    assign not_equal = |diff;
    assign less_than = diff[width-1] ^ sub_ovf;  // signed a < b

    always_comb begin
        overflow = 1'b0;
        case (op)
            cpu_pkg::alu_add: begin
                result   = sum;
                overflow = add_ovf;
            end
            cpu_pkg::alu_sub: begin
                result   = diff;
                overflow = sub_ovf;
            end
            cpu_pkg::alu_and: result = a & b;
            cpu_pkg::alu_or:  result = a | b;
            cpu_pkg::alu_sll: result = a << shamt;
            cpu_pkg::alu_sra: result = $signed(a) >>> shamt;
            default:          result = sum;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/cpu_pkg.sv */
// core shared definitions
`default_nettype none

package cpu_pkg;

    localparam int data_width     = 32;
    localparam int reg_addr_width = 5;

    localparam logic [reg_addr_width-1:0] exc_reg  = 5'd30;
    localparam logic [reg_addr_width-1:0] link_reg = 5'd31;

    // opcodes
    localparam logic [4:0] op_rtype = 5'd0;
    localparam logic [4:0] op_j     = 5'd1;
    localparam logic [4:0] op_bne   = 5'd2;
    localparam logic [4:0] op_jal   = 5'd3;
    localparam logic [4:0] op_addi  = 5'd5;
    localparam logic [4:0] op_blt   = 5'd6;
    localparam logic [4:0] op_sw    = 5'd7;
    localparam logic [4:0] op_lw    = 5'd8;

    // alu function field of r-type
    localparam logic [4:0] alu_add = 5'd0;
    localparam logic [4:0] alu_sub = 5'd1;
    localparam logic [4:0] alu_and = 5'd2;
    localparam logic [4:0] alu_or  = 5'd3;
    localparam logic [4:0] alu_sll = 5'd4;
    localparam logic [4:0] alu_sra = 5'd5;

    // values written to r30 on overflow
    localparam logic [data_width-1:0] exc_add  = 32'd1;
    localparam logic [data_width-1:0] exc_addi = 32'd2;
    localparam logic [data_width-1:0] exc_sub  = 32'd3;

    typedef struct packed {
        logic [4:0]                opcode;
        logic [reg_addr_width-1:0] rd;
        logic [reg_addr_width-1:0] rs;
        logic [reg_addr_width-1:0] rt;
        logic [4:0]                shamt;
        logic [4:0]                alu_op;
        logic [1:0]                pad;     // unused low bits
    } r_view_t;

    typedef struct packed {
        logic [4:0]                opcode;
        logic [reg_addr_width-1:0] rd;
        logic [reg_addr_width-1:0] rs;
        logic [16:0]               imm;     // signed
    } i_view_t;

    typedef struct packed {
        logic [4:0]  opcode;
        logic [26:0] target;
    } j_view_t;

    typedef union packed {
        r_view_t r;
        i_view_t i;
        j_view_t j;
    } instr_t;

    typedef struct packed {
        logic [4:0]                alu_op;
        logic [4:0]                shamt;
        logic                      use_imm;
        logic                      is_load;
        logic                      is_store;
        logic                      is_bne;
        logic                      is_blt;
        logic                      is_jump;
        logic                      is_link;
        logic                      reg_write;
        logic [reg_addr_width-1:0] dest;
        logic [data_width-1:0]     exc_code;  // zero when no overflow trap
    } ctrl_t;

    typedef struct packed {
        logic [data_width-1:0]     pc_plus1;
        ctrl_t                     ctrl;
        logic [reg_addr_width-1:0] rs;
        logic [reg_addr_width-1:0] rt;        // second source index
        logic [data_width-1:0]     a;
        logic [data_width-1:0]     b;
        logic [data_width-1:0]     imm;
    } dx_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [data_width-1:0] result;
        logic [data_width-1:0] store_data;
    } xm_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [data_width-1:0] result;
        logic [data_width-1:0] load_data;
    } mw_t;

    typedef enum logic [1:0] {
        from_reg,
        from_xm,
        from_mw
    } fwd_sel_t;

endpackage

`default_nettype wire

/* rtl/execute_stage.sv */
// execute stage and execute/memory register
`timescale 1ns/100ps
`default_nettype none

module execute_stage #(
    parameter int width = 32
) (
    input  logic              clock,
    input  logic              reset,
    input  cpu_pkg::dx_t      dx,
    input  logic [width-1:0]  xm_fwd,
    input  logic [width-1:0]  mw_fwd,
    input  cpu_pkg::fwd_sel_t fwd_a,
    input  cpu_pkg::fwd_sel_t fwd_b,
    output logic              redirect,
    output logic [width-1:0]  redirect_pc,
    output cpu_pkg::xm_t      xm
);

    logic [width-1:0] op_a;
    logic [width-1:0] op_b;
    logic [width-1:0] alu_b;
    logic [width-1:0] alu_result;
    logic             overflow;
    logic             not_equal;
    logic             less_than;
    logic             taken;
    cpu_pkg::xm_t     xm_next;

    function automatic logic [width-1:0] fwd_mux(input cpu_pkg::fwd_sel_t sel,
                                                 input logic [width-1:0] reg_val,
                                                 input logic [width-1:0] xm_val,
                                                 input logic [width-1:0] mw_val);
        case (sel)
            cpu_pkg::from_xm: return xm_val;
            cpu_pkg::from_mw: return mw_val;
            default:          return reg_val;
        endcase
    endfunction

    assign op_a  = fwd_mux(fwd_a, dx.a, xm_fwd, mw_fwd);
    assign op_b  = fwd_mux(fwd_b, dx.b, xm_fwd, mw_fwd);  // rd value for sw and branches
    assign alu_b = dx.ctrl.use_imm ? dx.imm : op_b;

    alu #(
        .width(width)
    ) u_alu (
        .a        (op_a),
        .b        (alu_b),
        .op       (dx.ctrl.alu_op),
        .shamt    (dx.ctrl.shamt),
        .result   (alu_result),
        .overflow (overflow),
        .not_equal(not_equal),
        .less_than(less_than)
    );

    // a is rs, b is rd, so blt wants b < a
    assign taken = (dx.ctrl.is_bne && not_equal)
                 || (dx.ctrl.is_blt && not_equal && !less_than);

    assign redirect    = taken || dx.ctrl.is_jump;
    assign redirect_pc = dx.ctrl.is_jump ? dx.imm : dx.pc_plus1 + dx.imm;

    always_comb begin
        xm_next.ctrl       = dx.ctrl;
        xm_next.result     = dx.ctrl.is_link ? dx.pc_plus1 : alu_result;
        xm_next.store_data = op_b;
        if (overflow && (dx.ctrl.exc_code != '0)) begin
            // trap value goes to r30 in place of rd
            xm_next.ctrl.dest = cpu_pkg::exc_reg;
            xm_next.result    = dx.ctrl.exc_code;
        end
    end

    always_ff @(posedge clock) begin
        xm <= xm_next;
        if (reset) begin
            xm.ctrl <= '0;
        end
    end

endmodule

`default_nettype wire

/* rtl/fetch_unit.sv */
// program counter and fetch stage
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            stall,
    input  logic                            redirect,
    input  logic [cpu_pkg::data_width-1:0]  redirect_pc,
    output logic [cpu_pkg::data_width-1:0]  address_imem,
    input  logic [cpu_pkg::data_width-1:0]  q_imem,
    output logic [cpu_pkg::data_width-1:0]  fd_pc,
    output cpu_pkg::instr_t                 fd_instr
);

    logic [cpu_pkg::data_width-1:0] pc;

    assign address_imem = pc;  // word address

    always_ff @(posedge clock) begin
        if (reset) begin
            pc       <= '0;
            fd_instr <= '0;
        end else if (redirect) begin
            pc       <= redirect_pc;
            fd_instr <= '0;  // squash the wrong-path fetch
        end else if (!stall) begin
            pc       <= pc + 32'd1;
            fd_instr <= q_imem;
        end
    end

    // pc of the instruction held in decode
    always_ff @(posedge clock) begin
        if (redirect || !stall) begin
            fd_pc <= pc;
        end
    end

endmodule

`default_nettype wire

/* rtl/hazard_unit.sv */
// forwarding and load-use detection
`timescale 1ns/100ps
`default_nettype none

module hazard_unit (
    input  logic [cpu_pkg::reg_addr_width-1:0] dx_rs,
    input  logic [cpu_pkg::reg_addr_width-1:0] dx_rt,
    input  logic [cpu_pkg::reg_addr_width-1:0] fd_rs,
    input  logic [cpu_pkg::reg_addr_width-1:0] fd_rt,
    input  cpu_pkg::ctrl_t                     dx_ctrl,
    input  cpu_pkg::ctrl_t                     xm_ctrl,
    input  cpu_pkg::ctrl_t                     mw_ctrl,
    output cpu_pkg::fwd_sel_t                  fwd_a,
    output cpu_pkg::fwd_sel_t                  fwd_b,
    output logic                               fwd_store,
    output logic                               fwd_dec_a,
    output logic                               fwd_dec_b,
    output logic                               stall
);

    // does stage c write register r (r0 never matches)
    function automatic logic writes(input cpu_pkg::ctrl_t c,
                                    input logic [cpu_pkg::reg_addr_width-1:0] r);
        return c.reg_write && (r != '0) && (c.dest == r);
    endfunction

    function automatic cpu_pkg::fwd_sel_t pick(input logic [cpu_pkg::reg_addr_width-1:0] r,
                                               input cpu_pkg::ctrl_t xm_c,
                                               input cpu_pkg::ctrl_t mw_c);
        if (writes(xm_c, r)) begin
            return cpu_pkg::from_xm;  // youngest producer wins
        end else if (writes(mw_c, r)) begin
            return cpu_pkg::from_mw;
        end
        return cpu_pkg::from_reg;
    endfunction

    assign fwd_a = pick(dx_rs, xm_ctrl, mw_ctrl);
    assign fwd_b = pick(dx_rt, xm_ctrl, mw_ctrl);

    // store in memory, its data register written by writeback
    assign fwd_store = xm_ctrl.is_store && writes(mw_ctrl, xm_ctrl.dest);

    // regfile write lands at the edge, too late for the decode read
    assign fwd_dec_a = writes(mw_ctrl, fd_rs);
    assign fwd_dec_b = writes(mw_ctrl, fd_rt);

    // load data only exists after the memory stage
    assign stall = dx_ctrl.is_load && (writes(dx_ctrl, fd_rs) || writes(dx_ctrl, fd_rt));

endmodule

`default_nettype wire

/* rtl/instr_decoder.sv */
// instruction decoder
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
    input  cpu_pkg::instr_t instr,
    output cpu_pkg::ctrl_t  ctrl
);

    always_comb begin
        ctrl = '0;  // unknown opcodes fall through as a bubble
        case (instr.r.opcode)
            cpu_pkg::op_rtype: begin
                ctrl.alu_op = instr.r.alu_op;
                ctrl.shamt  = instr.r.shamt;
                ctrl.dest   = instr.r.rd;
                case (instr.r.alu_op)
                    cpu_pkg::alu_add: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.exc_code  = cpu_pkg::exc_add;
                    end
                    cpu_pkg::alu_sub: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.exc_code  = cpu_pkg::exc_sub;
                    end
                    cpu_pkg::alu_and, cpu_pkg::alu_or,
                    cpu_pkg::alu_sll, cpu_pkg::alu_sra: ctrl.reg_write = 1'b1;
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            cpu_pkg::op_addi: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dest      = instr.i.rd;
                ctrl.exc_code  = cpu_pkg::exc_addi;
            end
            cpu_pkg::op_lw: begin
                ctrl.use_imm   = 1'b1;
                ctrl.is_load   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dest      = instr.i.rd;
            end
            cpu_pkg::op_sw: begin
                ctrl.use_imm  = 1'b1;
                ctrl.is_store = 1'b1;
                ctrl.dest     = instr.i.rd;  // store data source, never written
            end
            cpu_pkg::op_bne: begin
                ctrl.is_bne = 1'b1;
                ctrl.alu_op = cpu_pkg::alu_sub;
            end
            cpu_pkg::op_blt: begin
                ctrl.is_blt = 1'b1;
                ctrl.alu_op = cpu_pkg::alu_sub;
            end
            cpu_pkg::op_j: ctrl.is_jump = 1'b1;
            cpu_pkg::op_jal: begin
                ctrl.is_jump   = 1'b1;
                ctrl.is_link   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dest      = cpu_pkg::link_reg;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/processor.sv */
// five-stage pipelined core
`timescale 1ns/100ps
`default_nettype none

module processor (
    input  logic                                clock,
    input  logic                                reset,
    output logic [cpu_pkg::data_width-1:0]      address_imem,
    input  logic [cpu_pkg::data_width-1:0]      q_imem,
    output logic [cpu_pkg::data_width-1:0]      address_dmem,
    output logic [cpu_pkg::data_width-1:0]      data,
    output logic                                wren,
    input  logic [cpu_pkg::data_width-1:0]      q_dmem,
    output logic                                ctrl_write_enable,
    output logic [cpu_pkg::reg_addr_width-1:0]  ctrl_write_reg,
    output logic [cpu_pkg::reg_addr_width-1:0]  ctrl_read_reg_a,
    output logic [cpu_pkg::reg_addr_width-1:0]  ctrl_read_reg_b,
    output logic [cpu_pkg::data_width-1:0]      data_write_reg,
    input  logic [cpu_pkg::data_width-1:0]      data_read_reg_a,
    input  logic [cpu_pkg::data_width-1:0]      data_read_reg_b
);

    logic [cpu_pkg::data_width-1:0] fd_pc;
    cpu_pkg::instr_t                fd_instr;
    cpu_pkg::ctrl_t                 fd_ctrl;
    cpu_pkg::dx_t                   dx_next;
    cpu_pkg::dx_t                   dx;
    cpu_pkg::xm_t                   xm;
    cpu_pkg::mw_t                   mw;
    cpu_pkg::fwd_sel_t              fwd_a;
    cpu_pkg::fwd_sel_t              fwd_b;
    logic                           fwd_store;
    logic                           fwd_dec_a;
    logic                           fwd_dec_b;
    logic                           stall;
    logic                           redirect;
    logic [cpu_pkg::data_width-1:0] redirect_pc;
    logic [cpu_pkg::data_width-1:0] wb_data;
    logic                           read_rd;

    fetch_unit u_fetch (
        .clock       (clock),
        .reset       (reset),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .address_imem(address_imem),
        .q_imem      (q_imem),
        .fd_pc       (fd_pc),
        .fd_instr    (fd_instr)
    );

    instr_decoder u_decoder (
        .instr(fd_instr),
        .ctrl (fd_ctrl)
    );

    // sw and branches compare or store rd, so it goes on port b
    assign read_rd         = fd_ctrl.is_store || fd_ctrl.is_bne || fd_ctrl.is_blt;
    assign ctrl_read_reg_a = fd_instr.r.rs;
    assign ctrl_read_reg_b = read_rd ? fd_instr.r.rd : fd_instr.r.rt;

    hazard_unit u_hazard (
        .dx_rs    (dx.rs),
        .dx_rt    (dx.rt),
        .fd_rs    (ctrl_read_reg_a),
        .fd_rt    (ctrl_read_reg_b),
        .dx_ctrl  (dx.ctrl),
        .xm_ctrl  (xm.ctrl),
        .mw_ctrl  (mw.ctrl),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b),
        .fwd_store(fwd_store),
        .fwd_dec_a(fwd_dec_a),
        .fwd_dec_b(fwd_dec_b),
        .stall    (stall)
    );

    always_comb begin
        dx_next.pc_plus1 = fd_pc + 32'd1;
        dx_next.ctrl     = fd_ctrl;
        dx_next.rs       = ctrl_read_reg_a;
        dx_next.rt       = ctrl_read_reg_b;
        dx_next.a        = fwd_dec_a ? wb_data : data_read_reg_a;
        dx_next.b        = fwd_dec_b ? wb_data : data_read_reg_b;
        if (fd_ctrl.is_jump) begin
            dx_next.imm = {5'b0, fd_instr.j.target};  // absolute target
        end else begin
            dx_next.imm = {{15{fd_instr.i.imm[16]}}, fd_instr.i.imm};
        end
    end

    always_ff @(posedge clock) begin
        dx <= dx_next;
        if (reset || stall || redirect) begin
            dx.ctrl <= '0;  // bubble
        end
    end

    execute_stage #(
        .width(cpu_pkg::data_width)
    ) u_execute (
        .clock      (clock),
        .reset      (reset),
        .dx         (dx),
        .xm_fwd     (xm.result),
        .mw_fwd     (wb_data),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .xm         (xm)
    );

    // memory stage
    assign address_dmem = xm.result;
    assign data         = fwd_store ? wb_data : xm.store_data;
    assign wren         = xm.ctrl.is_store;

    always_ff @(posedge clock) begin
        mw.result    <= xm.result;
        mw.load_data <= q_dmem;
        if (reset) begin
            mw.ctrl <= '0;
        end else begin
            mw.ctrl <= xm.ctrl;
        end
    end

    // writeback
    assign wb_data           = mw.ctrl.is_load ? mw.load_data : mw.result;
    assign data_write_reg    = wb_data;
    assign ctrl_write_reg    = mw.ctrl.dest;
    assign ctrl_write_enable = mw.ctrl.reg_write && (mw.ctrl.dest != '0);  // r0 stays zero

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the processor testbench with Verilator
verilator --binary --timing --assert --top-module tb_processor -f list.f -Mdir obj_dir \
    -o sim_tb_processor > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb_processor > sim.log 2>&1 || true
cat sim.log
grep -q "^Finished with no errors$" sim.log && ! grep -q "^Finished with errors$" sim.log

/* verif/processor_asserts.sv */
// processor port assertions
`timescale 1ns/100ps
`default_nettype none

module processor_asserts (
    input logic        clock,
    input logic        reset,
    input logic        wren,
    input logic        ctrl_write_enable,
    input logic [4:0]  ctrl_write_reg,
    input logic [31:0] address_imem
);

    no_r0_write: assert property (@(posedge clock) disable iff (reset)
        ctrl_write_enable |-> ctrl_write_reg != '0)
        else $error("register write targets r0");

    // first reset edge clears the pipe, later ones must be quiet
    quiet_in_reset: assert property (@(posedge clock)
        reset && $past(reset) |-> !wren && !ctrl_write_enable)
        else $error("write enable high during reset");

    pc_starts_at_zero: assert property (@(posedge clock)
        $fell(reset) |-> address_imem == '0)
        else $error("fetch address not zero after reset");

endmodule

bind processor processor_asserts u_asserts (
    .clock            (clock),
    .reset            (reset),
    .wren             (wren),
    .ctrl_write_enable(ctrl_write_enable),
    .ctrl_write_reg   (ctrl_write_reg),
    .address_imem     (address_imem)
);

`default_nettype wire

/* verif/tb_processor.sv */
// processor testbench
`timescale 1ns/100ps
`default_nettype none

module tb_processor;

    localparam int n_instr    = 200;
    localparam int imem_size  = 256;
    localparam int dmem_size  = 64;
    localparam int max_cycles = 3 * n_instr + 50;

    typedef struct packed {
        logic [cpu_pkg::reg_addr_width-1:0] idx;
        logic [cpu_pkg::data_width-1:0]     value;
    } reg_wr_t;

    typedef struct packed {
        logic [cpu_pkg::data_width-1:0] addr;
        logic [cpu_pkg::data_width-1:0] value;
    } mem_wr_t;

    logic                               clock = 1'b0;
    logic                               reset;
    logic [cpu_pkg::data_width-1:0]     address_imem;
    logic [cpu_pkg::data_width-1:0]     q_imem;
    logic [cpu_pkg::data_width-1:0]     address_dmem;
    logic [cpu_pkg::data_width-1:0]     data;
    logic                               wren;
    logic [cpu_pkg::data_width-1:0]     q_dmem;
    logic                               ctrl_write_enable;
    logic [cpu_pkg::reg_addr_width-1:0] ctrl_write_reg;
    logic [cpu_pkg::reg_addr_width-1:0] ctrl_read_reg_a;
    logic [cpu_pkg::reg_addr_width-1:0] ctrl_read_reg_b;
    logic [cpu_pkg::data_width-1:0]     data_write_reg;
    logic [cpu_pkg::data_width-1:0]     data_read_reg_a;
    logic [cpu_pkg::data_width-1:0]     data_read_reg_b;

    logic [cpu_pkg::data_width-1:0] imem [imem_size];
    logic [cpu_pkg::data_width-1:0] dmem [dmem_size];
    logic [cpu_pkg::data_width-1:0] regs [32];
    logic [cpu_pkg::data_width-1:0] init_regs [32];
    logic [cpu_pkg::data_width-1:0] m_regs [32];      // reference model state
    logic [cpu_pkg::data_width-1:0] m_mem [dmem_size];

    reg_wr_t exp_regs[$];
    mem_wr_t exp_mems[$];
    int      cycles = 0;
    int      reg_errors = 0;
    int      mem_errors = 0;
    int      other_errors = 0;

    processor uut (
        .clock            (clock),
        .reset            (reset),
        .address_imem     (address_imem),
        .q_imem           (q_imem),
        .address_dmem     (address_dmem),
        .data             (data),
        .wren             (wren),
        .q_dmem           (q_dmem),
        .ctrl_write_enable(ctrl_write_enable),
        .ctrl_write_reg   (ctrl_write_reg),
        .ctrl_read_reg_a  (ctrl_read_reg_a),
        .ctrl_read_reg_b  (ctrl_read_reg_b),
        .data_write_reg   (data_write_reg),
        .data_read_reg_a  (data_read_reg_a),
        .data_read_reg_b  (data_read_reg_b)
    );

    always #20 clock = ~clock;

    // storage around the core, reads are combinational
    assign q_imem = (address_imem < imem_size) ? imem[address_imem[7:0]] : '0;
    assign q_dmem = (address_dmem < dmem_size) ? dmem[address_dmem[5:0]] : '0;
    assign data_read_reg_a = regs[ctrl_read_reg_a];
    assign data_read_reg_b = regs[ctrl_read_reg_b];

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= init_regs[i];
            end
            for (int i = 0; i < dmem_size; i++) begin
                dmem[i] <= '0;
            end
        end else begin
            if (ctrl_write_enable) begin
                regs[ctrl_write_reg] <= data_write_reg;
            end
            if (wren && (address_dmem < dmem_size)) begin
                dmem[address_dmem[5:0]] <= data;
            end
        end
    end

    function automatic logic [cpu_pkg::reg_addr_width-1:0] rand_reg();
        return 5'($urandom % 8);  // r0..r7 keeps hazards frequent
    endfunction

    function automatic logic [cpu_pkg::data_width-1:0] random_instr(input int pc);
        cpu_pkg::instr_t ins;
        int              pick;
        ins  = '0;
        pick = int'($urandom % 12);
        if (pick < 6) begin
            ins.r.opcode = cpu_pkg::op_rtype;
            ins.r.rd     = rand_reg();
            ins.r.rs     = rand_reg();
            ins.r.rt     = rand_reg();
            ins.r.shamt  = 5'($urandom % 32);
            ins.r.alu_op = 5'($urandom % 6);
        end else begin
            case (pick)
                6: begin
                    ins.i.opcode = cpu_pkg::op_addi;
                    ins.i.rd     = rand_reg();
                    ins.i.rs     = rand_reg();
                    ins.i.imm    = 17'($urandom);
                end
                7, 8: begin
                    ins.i.opcode = (pick == 7) ? cpu_pkg::op_lw : cpu_pkg::op_sw;
                    ins.i.rd     = rand_reg();
                    ins.i.rs     = '0;  // address is just imm
                    ins.i.imm    = 17'($urandom % dmem_size);
                end
                9, 10: begin
                    ins.i.opcode = (pick == 9) ? cpu_pkg::op_bne : cpu_pkg::op_blt;
                    ins.i.rd     = rand_reg();
                    ins.i.rs     = rand_reg();
                    ins.i.imm    = 17'($urandom % 4 + 1);  // skip 1 to 4
                end
                default: begin
                    ins.j.opcode = ($urandom % 2 == 0) ? cpu_pkg::op_j : cpu_pkg::op_jal;
                    ins.j.target = 27'(pc + 2 + int'($urandom % 4));
                end
            endcase
        end
        return ins;
    endfunction

    task automatic model_reg_write(input logic [cpu_pkg::reg_addr_width-1:0] idx,
                                   input logic [cpu_pkg::data_width-1:0] value);
        reg_wr_t w;
        w.idx   = idx;
        w.value = value;
        if (idx != '0) begin
            m_regs[idx] = value;
            exp_regs.push_back(w);
        end
    endtask

    // instruction-level simulator of the program
    task automatic run_model();
        cpu_pkg::instr_t                ins;
        logic [cpu_pkg::data_width-1:0] pc;
        logic [cpu_pkg::data_width-1:0] next_pc;
        logic [cpu_pkg::data_width-1:0] a;
        logic [cpu_pkg::data_width-1:0] b;
        logic [cpu_pkg::data_width-1:0] imm;
        logic [cpu_pkg::data_width-1:0] res;
        longint                         wide;
        logic                           ovf;
        mem_wr_t                        mw;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = init_regs[i];
        end
        for (int i = 0; i < dmem_size; i++) begin
            m_mem[i] = '0;
        end
        pc = '0;
        while (pc < n_instr) begin
            ins     = imem[pc[7:0]];
            imm     = {{15{ins.i.imm[16]}}, ins.i.imm};
            a       = m_regs[ins.r.rs];
            b       = m_regs[ins.r.rt];
            next_pc = pc + 1;
            ovf     = 1'b0;
            case (ins.r.opcode)
                cpu_pkg::op_rtype: begin
                    case (ins.r.alu_op)
                        cpu_pkg::alu_add: begin
                            res  = a + b;
                            wide = longint'($signed(a)) + longint'($signed(b));
                            ovf  = wide != longint'($signed(res));  // exact sum does not fit
                        end
                        cpu_pkg::alu_sub: begin
                            res  = a - b;
                            wide = longint'($signed(a)) - longint'($signed(b));
                            ovf  = wide != longint'($signed(res));
                        end
                        cpu_pkg::alu_and: res = a & b;
                        cpu_pkg::alu_or:  res = a | b;
                        cpu_pkg::alu_sll: res = a << ins.r.shamt;
                        default:          res = $signed(a) >>> ins.r.shamt;
                    endcase
                    if (ovf) begin
                        model_reg_write(cpu_pkg::exc_reg, (ins.r.alu_op == cpu_pkg::alu_add) ?
                                        cpu_pkg::exc_add : cpu_pkg::exc_sub);
                    end else begin
                        model_reg_write(ins.r.rd, res);
                    end
                end
                cpu_pkg::op_addi: begin
                    res  = a + imm;
                    wide = longint'($signed(a)) + longint'($signed(imm));
                    if (wide != longint'($signed(res))) begin
                        model_reg_write(cpu_pkg::exc_reg, cpu_pkg::exc_addi);
                    end else begin
                        model_reg_write(ins.i.rd, res);
                    end
                end
                cpu_pkg::op_lw: begin
                    res = a + imm;
                    model_reg_write(ins.i.rd, m_mem[res[5:0]]);
                end
                cpu_pkg::op_sw: begin
                    mw.addr  = a + imm;
                    mw.value = m_regs[ins.i.rd];
                    m_mem[mw.addr[5:0]] = mw.value;
                    exp_mems.push_back(mw);
                end
                cpu_pkg::op_bne: begin
                    if (m_regs[ins.i.rd] != a) next_pc = pc + 1 + imm;
                end
                cpu_pkg::op_blt: begin
                    if ($signed(m_regs[ins.i.rd]) < $signed(a)) next_pc = pc + 1 + imm;
                end
                cpu_pkg::op_jal: begin
                    model_reg_write(cpu_pkg::link_reg, pc + 1);
                    next_pc = {5'b0, ins.j.target};
                end
                default: next_pc = {5'b0, ins.j.target};  // j
            endcase
            pc = next_pc;
        end
    endtask

    task automatic check_reg_write(input logic [cpu_pkg::reg_addr_width-1:0] idx,
                                   input logic [cpu_pkg::data_width-1:0] value);
        reg_wr_t exp;
        if (exp_regs.size() == 0) begin
            $display("unexpected register write to r%0d at %0t", idx, $time);
            reg_errors++;
        end else begin
            exp = exp_regs.pop_front();
            if (exp.idx !== idx || exp.value !== value) begin
                $display("Fail %0t: register write r%0d = %h, expected r%0d = %h",
                         $time, idx, value, exp.idx, exp.value);
                reg_errors++;
            end
        end
    endtask

    task automatic check_mem_write(input logic [cpu_pkg::data_width-1:0] addr,
                                   input logic [cpu_pkg::data_width-1:0] value);
        mem_wr_t exp;
        if (exp_mems.size() == 0) begin
            $display("unexpected memory write to %0d at %0t", addr, $time);
            mem_errors++;
        end else begin
            exp = exp_mems.pop_front();
            if (exp.addr !== addr || exp.value !== value) begin
                $display("Fail %0t: memory write [%0d] = %h, expected [%0d] = %h",
                         $time, addr, value, exp.addr, exp.value);
                mem_errors++;
            end
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clock) begin
        if (!reset) begin
            if (ctrl_write_enable) check_reg_write(ctrl_write_reg, data_write_reg);
            if (wren) check_mem_write(address_dmem, data);
        end
    end

    initial begin
        reg_wr_t r;
        mem_wr_t m;
        void'($urandom(32'hdf13));
        reset = 1'b1;
        for (int i = 0; i < 32; i++) begin
            init_regs[i] = '0;
        end
        for (int i = 1; i < 8; i++) begin
            init_regs[i] = ($urandom % 2 == 0) ? $urandom : $urandom % 8;
        end
        for (int i = 0; i < imem_size; i++) begin
            imem[i] = (i < n_instr) ? random_instr(i) : '0;  // nop past the end
        end
        run_model();
        repeat (3) @(posedge clock);
        #1 reset = 1'b0;
        while ((exp_regs.size() != 0 || exp_mems.size() != 0) && cycles < max_cycles) begin
            @(posedge clock);
        end
        if (exp_regs.size() != 0 || exp_mems.size() != 0) begin
            $display("run did not finish within %0d cycles", max_cycles);
            other_errors++;
        end
        repeat (10) @(posedge clock);  // stray writes after the last retire
        while (exp_regs.size() != 0) begin
            r = exp_regs.pop_front();
            $display("missing register write r%0d = %h", r.idx, r.value);
            reg_errors++;
        end
        while (exp_mems.size() != 0) begin
            m = exp_mems.pop_front();
            $display("missing memory write [%0d] = %h", m.addr, m.value);
            mem_errors++;
        end
        $display("register errors %0d, memory errors %0d, other errors %0d",
                 reg_errors, mem_errors, other_errors);
        if (reg_errors + mem_errors + other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
